// ==== tb.f ====
+incdir+common
common/rtd_pkg.sv
spi_engine/spi_byte_engine.sv
ad7124_offload/ad7124_read_sequencer.sv
ad7124_buf/rtd_frame_buffer.sv
logic/ad7124_rtd_channel.sv
verif/ad7124_adc_model.sv
verif/tb_ad7124_rtd_channel.sv

// ==== Makefile ====
# Verilator build and run for the AD7124 RTD channel testbench

VERILATOR  ?= verilator
TOP        ?= tb_ad7124_rtd_channel
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed its pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_ad7124_rtd_channel.sv ====
//------------------------------------------------
// testbench for the ad7124 rtd channel
// random samples, pps snapshots and read-back
//------------------------------------------------

`include "rtd_macros.svh"

module tb_ad7124_rtd_channel;

    import rtd_pkg::*;

    localparam int N_FIRST  = 20;
    localparam int N_SECOND = 6;
    // trigger wait plus command and four data bytes plus slack
    localparam int READ_CYCLES    = 300 + 5 * 8 * 2 * (int'(`RTD_CLK_DIV) + 1) + 100;
    localparam int TIMEOUT_CYCLES = (N_FIRST + N_SECOND) * READ_CYCLES * 3 + 10000;
    // comms register byte with write enable low, read bit set and data register address 2
    localparam logic [7:0] READ_DATA_CMD = {1'b0, 1'b1, 6'h02};

    logic                 clk;
    logic                 arst_n;
    logic                 enable;
    logic                 pps;
    logic                 miso;
    logic                 miso_drv;
    logic                 adc_miso;
    logic                 sclk;
    logic                 mosi;
    logic                 cs_n;
    logic                 drdy;
    logic                 rd_en;
    logic [`RTD_CH_W-1:0] rd_addr;
    ad7124_sample_u       rd_data;
    logic                 push;
    logic [31:0]          push_word;
    logic [7:0]           adc_cmd;
    int                   adc_cmd_cnt;

    logic [31:0] sent_q [$];
    int          snap_words;
    int          writes_seen;
    int          drdy_cnt;
    int          pps_cnt;
    int          cmds_checked;
    int          reads_checked;
    int          errors;
    int          cycles;
    logic        drdy_prev;
    logic        rd_q;
    logic [31:0] exp_q;
    logic [31:0] rnd;
    string       test_name;
    string       name_q;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // tb can hold DOUT/RDY low on its own
    assign miso = adc_miso & miso_drv;

    ad7124_rtd_channel i_dut (
        .spi_clk_i(clk      ),
        .arst_n_i (arst_n   ),
        .enable_i (enable   ),
        .pps_i    (pps      ),
        .miso_i   (miso     ),
        .sclk_o   (sclk     ),
        .mosi_o   (mosi     ),
        .cs_n_o   (cs_n     ),
        .drdy_o   (drdy     ),
        .rd_en_i  (rd_en    ),
        .rd_addr_i(rd_addr  ),
        .rd_data_o(rd_data  )
    );

    ad7124_adc_model i_adc (
        .clk_i    (clk        ),
        .push_i   (push       ),
        .word_i   (push_word  ),
        .sclk_i   (sclk       ),
        .mosi_i   (mosi       ),
        .cs_n_i   (cs_n       ),
        .miso_o   (adc_miso   ),
        .cmd_o    (adc_cmd    ),
        .cmd_cnt_o(adc_cmd_cnt)
    );

    //------------------------------------------------
    // reference model and reporting
    //------------------------------------------------

    // latest word per channel over the first applied samples
    function automatic logic [31:0] expected_snapshot(input int applied, input int addr);
        logic [31:0] chan_tbl [`RTD_NUM_CH];
        for (int i = 0; i < `RTD_NUM_CH; i++) begin
            chan_tbl[i] = '0;
        end
        for (int i = 0; i < applied; i++) begin
            chan_tbl[sent_q[i][3:0]] = sent_q[i];
        end
        return chan_tbl[addr];
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] exp,
                                            input logic [31:0] act);
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        errors++;
    endfunction

    //------------------------------------------------
    // stimulus tasks
    //------------------------------------------------

    task automatic send_samples(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            rnd       = $urandom();
            // status byte is ready with no error and a random channel
            push_word = {rnd[23:0], 4'h0, rnd[27:24]};
            push      = 1'b1;
            sent_q.push_back(push_word);
        end
        @(negedge clk);
        push = 1'b0;
        while (writes_seen < sent_q.size()) begin
            @(negedge clk);
        end
    endtask

    task automatic pulse_pps();
        @(negedge clk);
        pps        = 1'b1;
        pps_cnt    = pps_cnt + 1;
        snap_words = sent_q.size();
        repeat (4) @(negedge clk);
        pps = 1'b0;
        while (drdy_cnt < pps_cnt) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic read_snapshot(input string name);
        for (int a = 0; a < `RTD_NUM_CH; a++) begin
            @(negedge clk);
            test_name = name;
            rd_en     = 1'b1;
            rd_addr   = a[`RTD_CH_W-1:0];
        end
        @(negedge clk);
        rd_en = 1'b0;
        @(negedge clk);
    endtask

    //------------------------------------------------
    // checkers and timeout
    //------------------------------------------------

    // expected word is taken with the request and compared once data is out
    always @(posedge clk) begin
        rd_q   <= rd_en;
        name_q <= test_name;
        exp_q  <= expected_snapshot(snap_words, int'(rd_addr));
    end

    always @(negedge clk) begin
        if (rd_q) begin
            reads_checked++;
            if (rd_data.raw !== exp_q) begin
                report_mismatch(name_q, exp_q, rd_data.raw);
            end
        end
        if (adc_cmd_cnt > cmds_checked) begin
            cmds_checked++;
            if (adc_cmd !== READ_DATA_CMD) begin
                report_mismatch("command", 32'(READ_DATA_CMD), 32'(adc_cmd));
            end
        end
    end

    always @(posedge clk) begin
        if (drdy && drdy_prev) begin
            $display("error: drdy_o stayed high for more than one cycle");
            errors++;
        end
        if (drdy && !drdy_prev) begin
            drdy_cnt <= drdy_cnt + 1;
        end
        drdy_prev <= drdy;
        if (i_dut.sample_wr.valid) begin
            writes_seen <= writes_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //------------------------------------------------
    // test sequence
    //------------------------------------------------

    initial begin
        rnd       = $urandom(61);
        arst_n    = 1'b0;
        enable    = 1'b0;
        pps       = 1'b0;
        miso_drv  = 1'b1;
        rd_en     = 1'b0;
        rd_addr   = '0;
        push      = 1'b0;
        push_word = '0;
        rd_q      = 1'b0;
        drdy_prev = 1'b0;
        test_name = "reset";
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (sclk !== 1'b1) begin
            report_mismatch("reset_sclk", 32'd1, 32'(sclk));
        end
        if (mosi !== 1'b1) begin
            report_mismatch("reset_mosi", 32'd1, 32'(mosi));
        end
        if (cs_n !== 1'b1) begin
            report_mismatch("reset_cs_n", 32'd1, 32'(cs_n));
        end
        if (drdy !== 1'b0) begin
            report_mismatch("reset_drdy", 32'd0, 32'(drdy));
        end

        // DOUT/RDY falls while the channel is off
        miso_drv = 1'b0;
        repeat (60) begin
            @(negedge clk);
            if (sclk !== 1'b1) begin
                report_mismatch("enable_off_sclk", 32'd1, 32'(sclk));
            end
            if (cs_n !== 1'b1) begin
                report_mismatch("enable_off_cs_n", 32'd1, 32'(cs_n));
            end
        end
        miso_drv = 1'b1;
        repeat (5) @(negedge clk);
        enable = 1'b1;
        repeat (5) @(negedge clk);

        send_samples(N_FIRST);
        pulse_pps();
        read_snapshot("snapshot_first");
        // new samples stay out of the snapshot until the next pps
        send_samples(N_SECOND);
        read_snapshot("hold_until_pps");
        pulse_pps();
        read_snapshot("snapshot_second");

        if (drdy_cnt != pps_cnt) begin
            report_mismatch("drdy_count", 32'(pps_cnt), 32'(drdy_cnt));
        end
        if (cmds_checked != sent_q.size()) begin
            report_mismatch("command_count", 32'(sent_q.size()), 32'(cmds_checked));
        end
        $display("done: %0d reads, %0d commands, %0d drdy pulses, %0d errors",
                 reads_checked, cmds_checked, drdy_cnt, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/ad7124_adc_model.sv ====
//------------------------------------------------
// behavioral ad7124
// signals ready on DOUT/RDY, takes the command
// byte and shifts out queued sample words
//------------------------------------------------

module ad7124_adc_model (
    input  logic        clk_i,
    input  logic        push_i,
    input  logic [31:0] word_i,
    input  logic        sclk_i,
    input  logic        mosi_i,
    input  logic        cs_n_i,
    output logic        miso_o,
    output logic [7:0]  cmd_o,
    output int          cmd_cnt_o
);

    logic [31:0] pending_q [$];
    logic [31:0] word;
    logic [7:0]  cmd;
    int          wait_cycles;

    always @(posedge clk_i) begin
        if (push_i) begin
            pending_q.push_back(word_i);
        end
    end

    initial begin
        miso_o    <= 1'b1;
        cmd_o     = '0;
        cmd_cnt_o = 0;
        forever begin
            @(negedge clk_i);
            if (pending_q.size() != 0 && !cs_n_i) begin
                word        = pending_q.pop_front();
                wait_cycles = $urandom_range(300, 50);
                repeat (wait_cycles) @(posedge clk_i);
                // conversion ready
                miso_o <= 1'b0;
                for (int i = 7; i >= 0; i--) begin
                    @(posedge sclk_i);
                    cmd[i] = mosi_i;
                end
                cmd_o     = cmd;
                cmd_cnt_o = cmd_cnt_o + 1;
                // data then status, msb first, new bit on each falling sclk
                for (int i = 31; i >= 0; i--) begin
                    @(negedge sclk_i);
                    miso_o <= word[i];
                end
                @(posedge sclk_i);
                miso_o <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/ad7124_rtd_channel.sv ====
//------------------------------------------------
// ad7124 rtd acquisition channel
// reads each ready conversion into a per-channel
// table and snapshots it on every pps
//------------------------------------------------

`include "rtd_macros.svh"

module ad7124_rtd_channel (
    input  logic                    spi_clk_i,
    input  logic                    arst_n_i,
    input  logic                    enable_i,
    input  logic                    pps_i,
    input  logic                    miso_i,
    output logic                    sclk_o,
    output logic                    mosi_o,
    output logic                    cs_n_o,
    output logic                    drdy_o,
    input  logic                    rd_en_i,
    input  logic [`RTD_CH_W-1:0]    rd_addr_i,
    output rtd_pkg::ad7124_sample_u rd_data_o
);

    import rtd_pkg::*;

    // sequencer to buffer
    sample_wr_t sample_wr;

    ad7124_read_sequencer i_ad7124_read_sequencer (
        .spi_clk_i(spi_clk_i),
        .arst_n_i (arst_n_i ),
        .enable_i (enable_i ),
        .miso_i   (miso_i   ),
        .sclk_o   (sclk_o   ),
        .mosi_o   (mosi_o   ),
        .cs_n_o   (cs_n_o   ),
        .sample_o (sample_wr)
    );

    rtd_frame_buffer i_rtd_frame_buffer (
        .spi_clk_i(spi_clk_i),
        .arst_n_i (arst_n_i ),
        .sample_i (sample_wr),
        .pps_i    (pps_i    ),
        .drdy_o   (drdy_o   ),
        .rd_en_i  (rd_en_i  ),
        .rd_addr_i(rd_addr_i),
        .rd_data_o(rd_data_o)
    );

endmodule

// ==== ad7124_buf/rtd_frame_buffer.sv ====
//------------------------------------------------
// rtd frame buffer
// live table per channel, snapshot on pps, read port
//------------------------------------------------

`include "rtd_macros.svh"

module rtd_frame_buffer (
    input  logic                    spi_clk_i,
    input  logic                    arst_n_i,
    input  rtd_pkg::sample_wr_t     sample_i,
    input  logic                    pps_i,
    output logic                    drdy_o,
    input  logic                    rd_en_i,
    input  logic [`RTD_CH_W-1:0]    rd_addr_i,
    output rtd_pkg::ad7124_sample_u rd_data_o
);

    import rtd_pkg::*;

    ad7124_sample_u       live_q [`RTD_NUM_CH];
    ad7124_sample_u       snap_q [`RTD_NUM_CH];
    ad7124_sample_u       rd_data_q;
    logic [`RTD_CH_W-1:0] wr_ch;
    logic                 pps_meta;
    logic                 pps_sync;
    logic                 pps_prev;
    logic                 pps_rise;
    logic                 drdy_q;

    // the status byte tells which channel was converted
    assign wr_ch    = sample_i.sample.fields.status.ch;
    assign pps_rise = pps_sync & ~pps_prev;

    always_ff @(posedge spi_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pps_meta <= 1'b0;
            pps_sync <= 1'b0;
            pps_prev <= 1'b0;
            drdy_q   <= 1'b0;
        end else begin
            pps_meta <= pps_i;
            pps_sync <= pps_meta;
            pps_prev <= pps_sync;
            drdy_q   <= pps_rise;
        end
    end

    //------------------------------------------------
    // live and snapshot banks
    //------------------------------------------------

    always_ff @(posedge spi_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RTD_NUM_CH; i++) begin
                live_q[i] <= '0;
                snap_q[i] <= '0;
            end
        end else begin
            if (sample_i.valid) begin
                live_q[wr_ch] <= sample_i.sample;
            end
            // snapshot takes the table as it was before this edge
            if (pps_rise) begin
                snap_q <= live_q;
            end
        end
    end

    // registered read, holds between requests
    always_ff @(posedge spi_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_data_q <= '0;
        end else if (rd_en_i) begin
            rd_data_q <= snap_q[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;
    assign drdy_o    = drdy_q;

    a_drdy_pulse : assert property (
        @(posedge spi_clk_i) disable iff (!arst_n_i)
        drdy_o |=> !drdy_o
    ) else $error("drdy high for more than one cycle");

endmodule

// ==== ad7124_offload/ad7124_read_sequencer.sv ====
//------------------------------------------------
// ad7124 read sequencer
// waits for DOUT/RDY low, reads the data register
// and hands the sample word to the buffer
//------------------------------------------------

`include "rtd_macros.svh"

module ad7124_read_sequencer (
    input  logic                spi_clk_i,
    input  logic                arst_n_i,
    input  logic                enable_i,
    input  logic                miso_i,
    output logic                sclk_o,
    output logic                mosi_o,
    output logic                cs_n_o,
    output rtd_pkg::sample_wr_t sample_o
);

    import rtd_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CMD_START,
        S_CMD,
        S_RX
    } state_t;

    state_t         state;
    logic           cs_n_q;
    logic           miso_meta;
    logic           miso_sync;
    logic           miso_prev;
    logic           rdy_fall;
    logic [2:0]     byte_cnt;
    logic           valid_q;
    ad7124_sample_u word_q;
    spi_req_t       spi_req;
    spi_rsp_t       spi_rsp;
    logic           spi_busy;

    //------------------------------------------------
    // chip select and DOUT/RDY detection
    //------------------------------------------------

    always_ff @(posedge spi_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cs_n_q    <= 1'b1;
            miso_meta <= 1'b1;
            miso_sync <= 1'b1;
            miso_prev <= 1'b1;
        end else begin
            cs_n_q    <= ~enable_i;
            miso_meta <= miso_i;
            miso_sync <= miso_meta;
            miso_prev <= miso_sync;
        end
    end

    // adc pulls DOUT/RDY low once a conversion is ready
    assign rdy_fall = miso_prev & ~miso_sync;

    //------------------------------------------------
    // read fsm
    //------------------------------------------------

    always_ff @(posedge spi_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= S_IDLE;
            spi_req  <= '0;
            byte_cnt <= '0;
            valid_q  <= 1'b0;
        end else begin
            spi_req.start <= 1'b0;
            valid_q       <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (rdy_fall && !cs_n_q) begin
                        state <= S_CMD_START;
                    end
                end
                S_CMD_START: begin
                    spi_req.start <= 1'b1;
                    spi_req.data  <= `RTD_CMD_READ_DATA;
                    state         <= S_CMD;
                end
                S_CMD: begin
                    // mosi held high while data comes back
                    if (spi_rsp.done) begin
                        spi_req.start <= 1'b1;
                        spi_req.data  <= 8'hff;
                        byte_cnt      <= '0;
                        state         <= S_RX;
                    end
                end
                S_RX: begin
                    if (spi_rsp.done) begin
                        if (byte_cnt == `RTD_READ_BYTES - 3'd1) begin
                            valid_q <= 1'b1;
                            state   <= S_IDLE;
                        end else begin
                            byte_cnt      <= byte_cnt + 3'd1;
                            spi_req.start <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // msb first, status byte lands in the low byte
    always_ff @(posedge spi_clk_i) begin
        if (state == S_RX && spi_rsp.done) begin
            word_q.raw <= {word_q.raw[23:0], spi_rsp.data};
        end
    end

    assign cs_n_o          = cs_n_q;
    assign sample_o.valid  = valid_q;
    assign sample_o.sample = word_q;

    spi_byte_engine i_spi_byte_engine (
        .spi_clk_i(spi_clk_i),
        .arst_n_i (arst_n_i ),
        .miso_i   (miso_sync),
        .req_i    (spi_req  ),
        .rsp_o    (spi_rsp  ),
        .busy_o   (spi_busy ),
        .sclk_o   (sclk_o   ),
        .mosi_o   (mosi_o   )
    );

    a_start_when_free : assert property (
        @(posedge spi_clk_i) disable iff (!arst_n_i)
        spi_req.start |-> !spi_busy
    ) else $error("byte start while engine busy");

    a_single_write : assert property (
        @(posedge spi_clk_i) disable iff (!arst_n_i)
        sample_o.valid |=> !sample_o.valid
    ) else $error("sample write on back-to-back cycles");

endmodule

// ==== spi_engine/spi_byte_engine.sv ====
//------------------------------------------------
// spi byte engine
// mode 3 shifter, one byte in and out per request
//------------------------------------------------

`include "rtd_macros.svh"

module spi_byte_engine (
    input  logic              spi_clk_i,
    input  logic              arst_n_i,
    input  logic              miso_i,
    input  rtd_pkg::spi_req_t req_i,
    output rtd_pkg::spi_rsp_t rsp_o,
    output logic              busy_o,
    output logic              sclk_o,
    output logic              mosi_o
);

    logic [7:0] div_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] tx_shift;
    logic [7:0] rx_shift;
    logic       busy_q;
    logic       done_q;
    logic       sclk_q;
    logic       mosi_q;
    logic       half_end;

    // each sclk half period is div + 1 clocks
    assign half_end = (div_cnt == `RTD_CLK_DIV);

    //------------------------------------------------
    // sclk generation and bit count
    //------------------------------------------------

    always_ff @(posedge spi_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            sclk_q  <= 1'b1;
            mosi_q  <= 1'b1;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                // first falling edge comes with the start
                if (req_i.start) begin
                    busy_q  <= 1'b1;
                    sclk_q  <= 1'b0;
                    mosi_q  <= req_i.data[7];
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (!half_end) begin
                div_cnt <= div_cnt + 8'd1;
            end else begin
                div_cnt <= '0;
                if (!sclk_q) begin
                    sclk_q <= 1'b1;
                end else if (bit_cnt == 3'd7) begin
                    // last high half done, back to idle
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                    mosi_q <= 1'b1;
                end else begin
                    sclk_q  <= 1'b0;
                    mosi_q  <= tx_shift[6];
                    bit_cnt <= bit_cnt + 3'd1;
                end
            end
        end
    end

    //------------------------------------------------
    // data shift registers
    //------------------------------------------------

    always_ff @(posedge spi_clk_i) begin
        if (!busy_q && req_i.start) begin
            tx_shift <= req_i.data;
        end else if (busy_q && half_end && sclk_q) begin
            tx_shift <= {tx_shift[6:0], 1'b1};
        end
        // miso sampled as sclk rises
        if (busy_q && half_end && !sclk_q) begin
            rx_shift <= {rx_shift[6:0], miso_i};
        end
    end

    assign rsp_o.done = done_q;
    assign rsp_o.data = rx_shift;
    assign busy_o     = busy_q;
    assign sclk_o     = sclk_q;
    assign mosi_o     = mosi_q;

    // mode 3 idles with the clock high
    a_sclk_idle_high : assert property (
        @(posedge spi_clk_i) disable iff (!arst_n_i)
        !busy_o |-> sclk_o
    ) else $error("sclk low while engine idle");

endmodule

// ==== common/rtd_pkg.sv ====
//------------------------------------------------
// rtd channel types
// spi transfer structs and the ad7124 sample word
//------------------------------------------------

package rtd_pkg;

    // one byte transfer request to the spi engine
    typedef struct packed {
        logic       start;
        logic [7:0] data;
    } spi_req_t;

    // byte received back, done is a single-cycle strobe
    typedef struct packed {
        logic       done;
        logic [7:0] data;
    } spi_rsp_t;

    // ad7124 status register layout
    typedef struct packed {
        logic       rdy_n;
        logic       err;
        logic       zero;
        logic       por;
        logic [3:0] ch;
    } ad7124_status_t;

    // data register read with status append enabled
    typedef struct packed {
        logic [23:0]    data;
        ad7124_status_t status;
    } ad7124_fields_t;

    // raw view is filled byte by byte, field view gives the channel
    typedef union packed {
        logic [31:0]    raw;
        ad7124_fields_t fields;
    } ad7124_sample_u;

    // sample write into the frame buffer
    typedef struct packed {
        logic           valid;
        ad7124_sample_u sample;
    } sample_wr_t;

endpackage

// ==== common/rtd_macros.svh ====
//------------------------------------------------
// rtd channel constants
// spi timing, ad7124 read command, table size
//------------------------------------------------

`ifndef RTD_MACROS_SVH
`define RTD_MACROS_SVH

// sclk = clock / ((div + 1) * 2)
`define RTD_CLK_DIV 8'd24

// comms register write: read, data register
`define RTD_CMD_READ_DATA 8'h42

// 24 data bits plus the appended status byte
`define RTD_READ_BYTES 3'd4

// latest-sample table, one entry per adc channel
`define RTD_NUM_CH 16
`define RTD_CH_W 4

`endif
